// File: tcp_rx_consts.svh
////////////////////////////////////////////////////////////
// tcp rx constants
// buffer geometry, sack block count and sequence width
// shared by the package, the rtl and the testbench
////////////////////////////////////////////////////////////

`ifndef TCP_RX_CONSTS_SVH
`define TCP_RX_CONSTS_SVH

// reorder buffer address width, buffer holds 2**aw bytes
`define TCP_RX_BUF_AW 8

// number of sack blocks reported in the option
`define TCP_RX_SACK_BLOCKS 4

// tcp sequence number width
`define TCP_RX_SEQ_W 32

// cycle budget for one segment, from its last payload byte
// up to the ack_req pulse, with margin for arbitration stalls
`define TCP_RX_DEC_TIMEOUT 200

`endif

// File: tcp_rx_pkg.sv
////////////////////////////////////////////////////////////
// tcp rx package
// sequence, address and byte types, the header, command,
// sack and buffer bus structs, and the tracker states
////////////////////////////////////////////////////////////

`default_nettype none

`include "tcp_rx_consts.svh"

package tcp_rx_pkg;

  // sequence numbers wrap, compare them by signed difference
  typedef logic [`TCP_RX_SEQ_W-1:0] seq_num_t;
  // low bits of a sequence number
  typedef logic [`TCP_RX_BUF_AW-1:0] buf_addr_t;
  typedef logic [7:0] rx_byte_t;

  // stop is start plus payload length
  typedef struct packed {
    seq_num_t start;
    seq_num_t stop;
  } seg_hdr_t;

  // store clear means consume and discard the payload
  typedef struct packed {
    logic      store;
    buf_addr_t base;
  } wr_cmd_t;

  typedef struct packed {
    seq_num_t left;
    seq_num_t right;
  } sack_block_t;

  // block 0 is the most recent one
  typedef struct packed {
    sack_block_t [`TCP_RX_SACK_BLOCKS-1:0] block;
    logic [`TCP_RX_SACK_BLOCKS-1:0]        present;
  } sack_opt_t;

  typedef struct packed {
    logic      we;
    buf_addr_t addr;
    rx_byte_t  wdata;
  } buf_req_t;

  typedef enum logic [2:0] {
    st_idle,
    st_check,
    st_load,
    st_merge,
    st_wait_data,
    st_commit
  } tracker_state_t;

endpackage

`default_nettype wire

// File: tcp_rx_sack_tracker.sv
////////////////////////////////////////////////////////////
// tcp rx sack tracker
// window check per segment, merge with the stored sack
// blocks, local ack update and ack request
////////////////////////////////////////////////////////////

`default_nettype none

`include "tcp_rx_consts.svh"

module tcp_rx_sack_tracker (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       init,
  input  wire tcp_rx_pkg::seq_num_t init_ack,
  input  wire tcp_rx_pkg::seg_hdr_t hdr,
  input  wire                       hdr_valid,
  output logic                      hdr_ready,
  output tcp_rx_pkg::wr_cmd_t       cmd,
  output logic                      cmd_valid,
  input  wire                       cmd_ready,
  input  wire                       seg_done,
  input  wire tcp_rx_pkg::seq_num_t rd_ptr,
  output tcp_rx_pkg::seq_num_t      loc_ack,
  output tcp_rx_pkg::sack_opt_t     sack,
  output logic                      ack_req
);

  localparam int NB = `TCP_RX_SACK_BLOCKS;
  localparam int IW = $clog2(NB);
  localparam tcp_rx_pkg::seq_num_t BUF_BYTES = 1 << `TCP_RX_BUF_AW;

  // a before b in modulo sequence space
  function automatic logic seq_lt(tcp_rx_pkg::seq_num_t a, tcp_rx_pkg::seq_num_t b);
    tcp_rx_pkg::seq_num_t d;
    d = a - b;
    return d[`TCP_RX_SEQ_W-1];
  endfunction

  function automatic logic seq_le(tcp_rx_pkg::seq_num_t a, tcp_rx_pkg::seq_num_t b);
    return !seq_lt(b, a);
  endfunction

  tcp_rx_pkg::tracker_state_t          state;
  // block built from the segment, widened by each merge
  tcp_rx_pkg::sack_block_t             new_blk;
  tcp_rx_pkg::sack_block_t             cur_blk;
  // blocks that survive the walk, in their old order
  tcp_rx_pkg::sack_block_t [NB-1:0]    kept_blk;
  logic [NB-1:0]                       kept_pres;
  logic [IW-1:0]                       kept_cnt;
  logic [IW-1:0]                       blk_idx;
  logic                                accepted;
  logic                                done_seen;
  logic                                start_ok;
  logic                                stop_ok;
  logic                                seg_empty;
  logic                                touch;

  ////////////////////////////////////////////////////////////
  // window test and command
  ////////////////////////////////////////////////////////////

  // start at or above the local ack
  assign start_ok  = seq_le(loc_ack, new_blk.left);
  // stop inside the free part of the buffer, unread bytes stay safe
  assign stop_ok   = seq_le(new_blk.right, rd_ptr + BUF_BYTES);
  // no payload follows an empty header, so no command goes out
  assign seg_empty = !seq_lt(new_blk.left, new_blk.right);

  assign cmd_valid = (state == tcp_rx_pkg::st_check) && !seg_empty;
  assign cmd.store = start_ok && stop_ok;
  assign cmd.base  = new_blk.left[`TCP_RX_BUF_AW-1:0];

  // overlap or adjacency, both edges inclusive
  assign touch = seq_le(cur_blk.left, new_blk.right) && seq_le(new_blk.left, cur_blk.right);

  ////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || init) begin
      state     <= tcp_rx_pkg::st_idle;
      hdr_ready <= 1'b0;
      loc_ack   <= init_ack;
      sack      <= '0;
      ack_req   <= 1'b0;
      accepted  <= 1'b0;
      done_seen <= 1'b0;
      blk_idx   <= '0;
      kept_cnt  <= '0;
      kept_pres <= '0;
    end else begin
      ack_req <= 1'b0;
      // writer may finish while the walk is still running
      if (seg_done) begin
        done_seen <= 1'b1;
      end
      case (state)
        tcp_rx_pkg::st_idle: begin
          if (hdr_ready && hdr_valid) begin
            new_blk.left  <= hdr.start;
            new_blk.right <= hdr.stop;
            hdr_ready     <= 1'b0;
            done_seen     <= 1'b0;
            state         <= tcp_rx_pkg::st_check;
          end else begin
            hdr_ready <= 1'b1;
          end
        end
        tcp_rx_pkg::st_check: begin
          accepted  <= start_ok && stop_ok && !seg_empty;
          blk_idx   <= '0;
          kept_cnt  <= '0;
          kept_pres <= '0;
          kept_blk  <= '0;
          if (seg_empty) begin
            state <= tcp_rx_pkg::st_commit;
          end else if (cmd_ready) begin
            // a dropped segment skips the merge walk
            state <= cmd.store ? tcp_rx_pkg::st_load : tcp_rx_pkg::st_wait_data;
          end
        end
        tcp_rx_pkg::st_load: begin
          // present blocks are packed from index 0
          if (sack.present[blk_idx]) begin
            cur_blk <= sack.block[blk_idx];
            state   <= tcp_rx_pkg::st_merge;
          end else begin
            state <= tcp_rx_pkg::st_wait_data;
          end
        end
        tcp_rx_pkg::st_merge: begin
          if (touch) begin
            // widen and free the old block
            new_blk.left  <= seq_lt(cur_blk.left, new_blk.left) ? cur_blk.left : new_blk.left;
            new_blk.right <= seq_lt(new_blk.right, cur_blk.right) ? cur_blk.right
                                                                  : new_blk.right;
          end else begin
            kept_blk[kept_cnt]  <= cur_blk;
            kept_pres[kept_cnt] <= 1'b1;
            kept_cnt            <= kept_cnt + 1'b1;
          end
          if (blk_idx == IW'(NB - 1)) begin
            state <= tcp_rx_pkg::st_wait_data;
          end else begin
            blk_idx <= blk_idx + 1'b1;
            state   <= tcp_rx_pkg::st_load;
          end
        end
        tcp_rx_pkg::st_wait_data: begin
          if (seg_done || done_seen) begin
            state <= tcp_rx_pkg::st_commit;
          end
        end
        tcp_rx_pkg::st_commit: begin
          if (accepted) begin
            if (new_blk.left == loc_ack) begin
              // gap filled, the merged block becomes acked data
              loc_ack      <= new_blk.right;
              sack.block   <= kept_blk;
              sack.present <= kept_pres;
            end else begin
              // newest first, the last kept block falls off
              sack.block[0] <= new_blk;
              for (int i = 1; i < NB; i++) begin
                sack.block[i] <= kept_blk[i-1];
              end
              sack.present <= {kept_pres[NB-2:0], 1'b1};
            end
          end
          ack_req   <= 1'b1;
          hdr_ready <= 1'b1;
          state     <= tcp_rx_pkg::st_idle;
        end
        default: begin
          state <= tcp_rx_pkg::st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  // no new header while a command is being offered
  a_cmd_hdr_excl: assert property (@(posedge clk) disable iff (reset || init)
    !(cmd_valid && hdr_ready));

  // local ack only moves forward outside of init
  a_ack_monotonic: assert property (@(posedge clk) disable iff (reset || init)
    $past(!reset && !init) |-> !seq_lt(loc_ack, $past(loc_ack)));

endmodule

`default_nettype wire

// File: tcp_rx_seg_writer.sv
////////////////////////////////////////////////////////////
// tcp rx segment writer
// stores or discards the payload of one segment
////////////////////////////////////////////////////////////

`default_nettype none

module tcp_rx_seg_writer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire tcp_rx_pkg::wr_cmd_t  cmd,
  input  wire                       cmd_valid,
  output logic                      cmd_ready,
  input  wire tcp_rx_pkg::rx_byte_t pay_data,
  input  wire                       pay_last,
  input  wire                       pay_valid,
  output logic                      pay_ready,
  output tcp_rx_pkg::buf_req_t      req,
  output logic                      req_valid,
  input  wire                       grant,
  output logic                      seg_done
);

  // command held until the last payload byte
  logic                  busy;
  logic                  store_q;
  tcp_rx_pkg::buf_addr_t addr_q;

  assign cmd_ready = !busy;

  // stored bytes go through the bus, one per grant
  assign req_valid = busy && store_q && pay_valid;
  assign req.we    = 1'b1;
  assign req.addr  = addr_q;
  assign req.wdata = pay_data;

  // discarded bytes drain at one per cycle
  assign pay_ready = busy && (!store_q || grant);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      seg_done <= 1'b0;
    end else begin
      seg_done <= 1'b0;
      if (cmd_valid && cmd_ready) begin
        busy <= 1'b1;
      end else if (pay_valid && pay_ready && pay_last) begin
        busy     <= 1'b0;
        seg_done <= 1'b1;
      end
    end
  end

  // latched command and running address
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      store_q <= cmd.store;
      addr_q  <= cmd.base;
    end else if (pay_valid && pay_ready) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // a waiting payload byte stays put until it is taken
  a_pay_held: assert property (@(posedge clk) disable iff (reset)
    (pay_valid && !pay_ready) |=> (pay_valid && $stable(pay_data) && $stable(pay_last)));

endmodule

`default_nettype wire

// File: tcp_rx_stream_reader.sv
////////////////////////////////////////////////////////////
// tcp rx stream reader
// releases in-order bytes from rd_ptr up to the local ack
////////////////////////////////////////////////////////////

`default_nettype none

`include "tcp_rx_consts.svh"

module tcp_rx_stream_reader (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       init,
  input  wire tcp_rx_pkg::seq_num_t init_ack,
  input  wire tcp_rx_pkg::seq_num_t loc_ack,
  output tcp_rx_pkg::buf_req_t      req,
  output logic                      req_valid,
  input  wire                       grant,
  input  wire tcp_rx_pkg::rx_byte_t rd_data,
  output tcp_rx_pkg::seq_num_t      rd_ptr,
  output tcp_rx_pkg::rx_byte_t      out_data,
  output logic                      out_valid,
  input  wire                       out_ready
);

  // one read in flight, data comes back next cycle
  logic pending;
  logic slot_free;

  // output register empties this cycle or is already empty
  assign slot_free = !out_valid || out_ready;

  assign req_valid = !pending && slot_free && (rd_ptr != loc_ack);
  assign req.we    = 1'b0;
  assign req.addr  = rd_ptr[`TCP_RX_BUF_AW-1:0];
  assign req.wdata = '0;

  always_ff @(posedge clk) begin
    if (reset || init) begin
      rd_ptr    <= init_ack;
      pending   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (pending) begin
        // byte lands in the output slot, pointer follows
        out_valid <= 1'b1;
        rd_ptr    <= rd_ptr + 1'b1;
        pending   <= 1'b0;
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (req_valid && grant) begin
        pending <= 1'b1;
      end
    end
  end

  // output byte, held while out_ready is low
  always_ff @(posedge clk) begin
    if (pending) begin
      out_data <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: tcp_rx_buf_arbiter.sv
////////////////////////////////////////////////////////////
// tcp rx buffer arbiter
// round-robin grant between writer and reader in front of
// the single-port reorder buffer
////////////////////////////////////////////////////////////

`default_nettype none

`include "tcp_rx_consts.svh"

module tcp_rx_buf_arbiter (
  input  wire                       clk,
  input  wire                       reset,
  input  wire tcp_rx_pkg::buf_req_t wr_req,
  input  wire                       wr_valid,
  output logic                      wr_grant,
  input  wire tcp_rx_pkg::buf_req_t rd_req,
  input  wire                       rd_valid,
  output logic                      rd_grant,
  output tcp_rx_pkg::rx_byte_t      rd_data
);

  localparam int DEPTH = 1 << `TCP_RX_BUF_AW;

  tcp_rx_pkg::rx_byte_t mem [DEPTH];
  tcp_rx_pkg::buf_req_t sel;
  // last winner was the writer
  logic                 last_wr;

  ////////////////////////////////////////////////////////////
  // grant
  ////////////////////////////////////////////////////////////

  // a lone requester wins at once, a tie goes to the other side
  assign wr_grant = wr_valid && (!rd_valid || !last_wr);
  assign rd_grant = rd_valid && (!wr_valid || last_wr);

  always_ff @(posedge clk) begin
    if (reset) begin
      last_wr <= 1'b0;
    end else if (wr_grant) begin
      last_wr <= 1'b1;
    end else if (rd_grant) begin
      last_wr <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory
  ////////////////////////////////////////////////////////////

  assign sel = wr_grant ? wr_req : rd_req;

  always_ff @(posedge clk) begin
    if (wr_grant || rd_grant) begin
      if (sel.we) begin
        mem[sel.addr] <= sel.wdata;
      end
      // registered read, valid the cycle after the grant
      rd_data <= mem[sel.addr];
    end
  end

  // the loser of a tie wins the next cycle if it still requests
  a_rd_turn: assert property (@(posedge clk) disable iff (reset)
    (wr_grant && rd_valid) |=> (!rd_valid || rd_grant));

  a_wr_turn: assert property (@(posedge clk) disable iff (reset)
    (rd_grant && wr_valid) |=> (!wr_valid || wr_grant));

endmodule

`default_nettype wire

// File: tcp_rx_top.sv
////////////////////////////////////////////////////////////
// tcp rx top
// sack tracker, segment writer, stream reader and buffer
// arbiter of one tcp receive connection
////////////////////////////////////////////////////////////

`default_nettype none

module tcp_rx_top (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       init,
  input  wire tcp_rx_pkg::seq_num_t init_ack,
  input  wire tcp_rx_pkg::seg_hdr_t hdr,
  input  wire                       hdr_valid,
  output logic                      hdr_ready,
  input  wire tcp_rx_pkg::rx_byte_t pay_data,
  input  wire                       pay_last,
  input  wire                       pay_valid,
  output logic                      pay_ready,
  output tcp_rx_pkg::rx_byte_t      out_data,
  output logic                      out_valid,
  input  wire                       out_ready,
  output tcp_rx_pkg::seq_num_t      loc_ack,
  output tcp_rx_pkg::sack_opt_t     sack,
  output logic                      ack_req
);

  // tracker to writer
  tcp_rx_pkg::wr_cmd_t  cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 seg_done;
  // buffer bus
  tcp_rx_pkg::buf_req_t wr_req;
  logic                 wr_valid;
  logic                 wr_grant;
  tcp_rx_pkg::buf_req_t rd_req;
  logic                 rd_valid;
  logic                 rd_grant;
  tcp_rx_pkg::rx_byte_t rd_data;
  // reader position for the window check
  tcp_rx_pkg::seq_num_t rd_ptr;

  tcp_rx_sack_tracker i_sack_tracker (
    .clk       (clk),
    .reset     (reset),
    .init      (init),
    .init_ack  (init_ack),
    .hdr       (hdr),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .seg_done  (seg_done),
    .rd_ptr    (rd_ptr),
    .loc_ack   (loc_ack),
    .sack      (sack),
    .ack_req   (ack_req)
  );

  tcp_rx_seg_writer i_seg_writer (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .pay_data  (pay_data),
    .pay_last  (pay_last),
    .pay_valid (pay_valid),
    .pay_ready (pay_ready),
    .req       (wr_req),
    .req_valid (wr_valid),
    .grant     (wr_grant),
    .seg_done  (seg_done)
  );

  tcp_rx_stream_reader i_stream_reader (
    .clk       (clk),
    .reset     (reset),
    .init      (init),
    .init_ack  (init_ack),
    .loc_ack   (loc_ack),
    .req       (rd_req),
    .req_valid (rd_valid),
    .grant     (rd_grant),
    .rd_data   (rd_data),
    .rd_ptr    (rd_ptr),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  tcp_rx_buf_arbiter i_buf_arbiter (
    .clk      (clk),
    .reset    (reset),
    .wr_req   (wr_req),
    .wr_valid (wr_valid),
    .wr_grant (wr_grant),
    .rd_req   (rd_req),
    .rd_valid (rd_valid),
    .rd_grant (rd_grant),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

// File: tb_tcp_rx_top.sv
////////////////////////////////////////////////////////////
// tcp rx testbench
// drives a table of segments into the receive path, checks
// loc_ack and sack against a block model after each ack_req
// and checks the released byte stream
////////////////////////////////////////////////////////////

`default_nettype none

`include "tcp_rx_consts.svh"

module tb_tcp_rx_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NB = `TCP_RX_SACK_BLOCKS;
  localparam int BUF_BYTES = 1 << `TCP_RX_BUF_AW;
  localparam int TMO = `TCP_RX_DEC_TIMEOUT;
  localparam int DRAIN_TMO = 20 * `TCP_RX_DEC_TIMEOUT;
  // close to the wrap point so offsets above 128 cross zero
  localparam tcp_rx_pkg::seq_num_t INIT_ACK = 32'hffff_ff80;

  // one row per segment, offsets relative to INIT_ACK
  typedef struct packed {
    int start_off;
    int len;
    int duty;
  } seg_row_t;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  init;
  tcp_rx_pkg::seq_num_t  init_ack;
  tcp_rx_pkg::seg_hdr_t  hdr;
  logic                  hdr_valid;
  logic                  hdr_ready;
  tcp_rx_pkg::rx_byte_t  pay_data;
  logic                  pay_last;
  logic                  pay_valid;
  logic                  pay_ready;
  tcp_rx_pkg::rx_byte_t  out_data;
  logic                  out_valid;
  logic                  out_ready;
  tcp_rx_pkg::seq_num_t  loc_ack;
  tcp_rx_pkg::sack_opt_t sack;
  logic                  ack_req;

  seg_row_t             rows[$];
  int                   row;
  int                   duty;
  // model state, offsets from INIT_ACK, block 0 newest
  int                   m_ack;
  int                   m_left[$];
  int                   m_right[$];
  int                   out_count;
  tcp_rx_pkg::seq_num_t exp_seq;
  int                   err_cnt;
  int                   tmo_cnt;
  int                   chk_cnt;

  tcp_rx_top i_tcp_rx_top (
    .clk       (clk),
    .reset     (reset),
    .init      (init),
    .init_ack  (init_ack),
    .hdr       (hdr),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready),
    .pay_data  (pay_data),
    .pay_last  (pay_last),
    .pay_valid (pay_valid),
    .pay_ready (pay_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .loc_ack   (loc_ack),
    .sack      (sack),
    .ack_req   (ack_req)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // segment table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input int s, input int l, input int d);
    seg_row_t r;
    r.start_off = s;
    r.len       = l;
    r.duty      = d;
    rows.push_back(r);
  endtask

  task automatic load_table();
    // in order
    add_row(0, 20, 100);
    add_row(20, 30, 60);
    // two holes, then fill them one at a time
    add_row(70, 10, 100);
    add_row(90, 10, 50);
    add_row(50, 20, 100);
    add_row(80, 10, 40);
    // below loc_ack, past the window, empty
    add_row(60, 10, 100);
    add_row(350, 20, 100);
    add_row(100, 0, 100);
    // five disjoint blocks, the first one is evicted
    add_row(110, 5, 100);
    add_row(120, 5, 70);
    add_row(130, 5, 100);
    add_row(140, 5, 45);
    add_row(150, 5, 100);
    add_row(100, 60, 30);
    // long segments under back-pressure
    add_row(160, 100, 35);
    add_row(270, 40, 50);
    add_row(260, 10, 70);
    add_row(310, 250, 80);
    add_row(600, 10, 100);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // rd_low is a lower bound of the reader position at the check
  task automatic apply_segment(input int s, input int e, input int rd_low);
    int nl;
    int nr;
    int kl[$];
    int kr[$];
    if (e <= s || s < m_ack || e > rd_low + BUF_BYTES) begin
      return;
    end
    nl = s;
    nr = e;
    foreach (m_left[i]) begin
      // touching blocks are absorbed into the new one
      if (m_left[i] <= nr && nl <= m_right[i]) begin
        if (m_left[i] < nl) nl = m_left[i];
        if (m_right[i] > nr) nr = m_right[i];
      end else begin
        kl.push_back(m_left[i]);
        kr.push_back(m_right[i]);
      end
    end
    if (nl == m_ack) begin
      m_ack = nr;
    end else begin
      kl.push_front(nl);
      kr.push_front(nr);
      if (kl.size() > NB) begin
        void'(kl.pop_back());
        void'(kr.pop_back());
      end
    end
    m_left  = kl;
    m_right = kr;
  endtask

  task automatic compare_status();
    tcp_rx_pkg::seq_num_t exp_ack;
    tcp_rx_pkg::seq_num_t exp_l;
    tcp_rx_pkg::seq_num_t exp_r;
    logic                 exp_p;
    chk_cnt++;
    exp_ack = INIT_ACK + tcp_rx_pkg::seq_num_t'(m_ack);
    assert (loc_ack == exp_ack) else begin
      err_cnt++;
      $display("[FAIL] loc_ack: got %h exp %h (segment %0d)", loc_ack, exp_ack, row);
    end
    for (int i = 0; i < NB; i++) begin
      exp_p = (i < m_left.size());
      assert (sack.present[i] == exp_p) else begin
        err_cnt++;
        $display("[FAIL] sack.present[%0d]: got %h exp %h", i, sack.present[i], exp_p);
      end
      if (exp_p) begin
        exp_l = INIT_ACK + tcp_rx_pkg::seq_num_t'(m_left[i]);
        exp_r = INIT_ACK + tcp_rx_pkg::seq_num_t'(m_right[i]);
        assert (sack.block[i].left == exp_l && sack.block[i].right == exp_r) else begin
          err_cnt++;
          $display("[FAIL] sack.block[%0d]: got %h..%h exp %h..%h", i,
                   sack.block[i].left, sack.block[i].right, exp_l, exp_r);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // drivers and waits
  ////////////////////////////////////////////////////////////

  task automatic drive_header(input tcp_rx_pkg::seg_hdr_t h, output bit ok);
    int n;
    @(negedge clk);
    hdr       = h;
    hdr_valid = 1'b1;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TMO) begin
      @(posedge clk);
      n++;
      if (hdr_ready) ok = 1'b1;
    end
    @(negedge clk);
    hdr_valid = 1'b0;
    if (!ok) begin
      tmo_cnt++;
      $display("timeout: header of segment %0d was never accepted", row);
    end
  endtask

  // each byte carries the low bits of its own sequence number
  task automatic drive_payload(input int s, input int len, output bit ok);
    int                   n;
    tcp_rx_pkg::seq_num_t seq;
    ok = 1'b1;
    for (int i = 0; i < len && ok; i++) begin
      @(negedge clk);
      seq       = INIT_ACK + tcp_rx_pkg::seq_num_t'(s + i);
      pay_data  = seq[7:0];
      pay_last  = (i == len - 1);
      pay_valid = 1'b1;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < TMO) begin
        @(posedge clk);
        n++;
        if (pay_ready) ok = 1'b1;
      end
      if (!ok) begin
        tmo_cnt++;
        $display("timeout: payload byte %0d of segment %0d was never taken", i, row);
      end
    end
    @(negedge clk);
    pay_valid = 1'b0;
    pay_last  = 1'b0;
  endtask

  task automatic wait_ack(output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TMO) begin
      @(posedge clk);
      n++;
      if (ack_req) ok = 1'b1;
    end
    if (!ok) begin
      tmo_cnt++;
      $display("timeout: no ack_req after segment %0d", row);
    end
  endtask

  // every acked byte has left the output
  task automatic wait_drain(output bit ok);
    int n;
    n  = 0;
    ok = (out_count == m_ack);
    while (!ok && n < DRAIN_TMO) begin
      @(posedge clk);
      n++;
      if (out_count == m_ack) ok = 1'b1;
    end
    if (!ok) begin
      tmo_cnt++;
      $display("timeout: output stalled at %0d of %0d bytes", out_count, m_ack);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  // random back-pressure at the duty of the current row
  initial begin
    int unsigned r;
    r = $urandom(32'ha171_6b52);
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      out_ready = ($urandom % 100) < duty;
    end
  end

  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      exp_seq = INIT_ACK + tcp_rx_pkg::seq_num_t'(out_count);
      assert (out_data == exp_seq[7:0]) else begin
        err_cnt++;
        $display("[FAIL] out_data: got %h exp %h (byte %0d)", out_data, exp_seq[7:0],
                 out_count);
      end
      assert (out_count < m_ack) else begin
        err_cnt++;
        $display("a byte was released beyond the acked data at byte %0d", out_count);
      end
      out_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bit                   ok;
    int                   snap;
    int                   s_off;
    int                   e_off;
    tcp_rx_pkg::seg_hdr_t h;
    reset     = 1'b1;
    init      = 1'b0;
    init_ack  = INIT_ACK;
    hdr       = '0;
    hdr_valid = 1'b0;
    pay_data  = '0;
    pay_last  = 1'b0;
    pay_valid = 1'b0;
    duty      = 100;
    m_ack     = 0;
    out_count = 0;
    err_cnt   = 0;
    tmo_cnt   = 0;
    chk_cnt   = 0;
    load_table();
    repeat (4) @(negedge clk);
    reset = 1'b0;
    ok = 1'b1;
    for (row = 0; row < rows.size() && ok; row++) begin
      s_off = rows[row].start_off;
      e_off = s_off + rows[row].len;
      duty  = rows[row].duty;
      // reader position is only known once the output has drained
      snap = out_count;
      if (e_off > snap + BUF_BYTES && e_off <= m_ack + BUF_BYTES) begin
        wait_drain(ok);
        snap = out_count;
      end
      h.start = INIT_ACK + tcp_rx_pkg::seq_num_t'(s_off);
      h.stop  = INIT_ACK + tcp_rx_pkg::seq_num_t'(e_off);
      if (ok) drive_header(h, ok);
      if (ok) drive_payload(s_off, rows[row].len, ok);
      if (ok) wait_ack(ok);
      if (ok) begin
        apply_segment(s_off, e_off, snap);
        compare_status();
      end
    end
    if (ok) wait_drain(ok);
    if (ok) begin
      assert (loc_ack - INIT_ACK == tcp_rx_pkg::seq_num_t'(out_count)) else begin
        err_cnt++;
        $display("[FAIL] out_count: got %h exp %h", out_count, loc_ack - INIT_ACK);
      end
    end
    $display("summary: %0d value errors, %0d timeouts, %0d status checks, %0d bytes",
             err_cnt, tmo_cnt, chk_cnt, out_count);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
tcp_rx_pkg.sv
tcp_rx_sack_tracker.sv
tcp_rx_seg_writer.sv
tcp_rx_stream_reader.sv
tcp_rx_buf_arbiter.sv
tcp_rx_top.sv
tb_tcp_rx_top.sv
